//--- calculator_vectors.txt
# k kind digit op : key event (kind 0 digit, 1 sign, 2 operator, 3 equal; op 0 add, 1 sub, 2 mul)
# e op sign mag   : expected result, magnitude in decimal
k 0 1 0
k 0 2 0
k 0 3 0
k 2 0 0
k 0 4 0
k 0 5 0
k 3 0 0
e 0 0 168
k 0 4 0
k 0 5 0
k 2 0 1
k 0 1 0
k 0 2 0
k 0 3 0
k 3 0 0
e 1 1 78
k 0 7 0
k 0 7 0
k 2 0 1
k 0 7 0
k 0 7 0
k 3 0 0
e 1 0 0
k 1 0 0
k 0 1 0
k 0 2 0
k 2 0 2
k 0 3 0
k 0 4 0
k 3 0 0
e 2 1 408
k 1 0 0
k 0 6 0
k 2 0 2
k 1 0 0
k 0 7 0
k 3 0 0
e 2 0 42
k 0 9 0
k 0 9 0
k 0 9 0
k 0 9 0
k 0 9 0
k 2 0 0
k 0 1 0
k 3 0 0
e 0 0 1696
k 0 3 0
k 0 0 0
k 0 0 0
k 2 0 2
k 0 2 0
k 0 0 0
k 0 0 0
k 3 0 0
e 2 0 27232
k 0 9 0
k 2 0 0
k 2 0 1
k 0 4 0
k 3 0 0
e 1 0 5
k 0 6 0
k 3 0 0
k 0 2 0
k 2 0 0
k 0 7 0
k 3 0 0
e 0 0 69
k 1 0 0
k 0 2 0
k 0 0 0
k 2 0 0
k 0 5 0
k 3 0 0
e 0 1 15
k 1 0 0
k 0 8 0
k 2 0 1
k 1 0 0
k 0 3 0
k 3 0 0
e 1 1 5

//--- calculator.f
+incdir+.
calc_pkg.sv
event_fifo.sv
sm_addsub.sv
sm_multiply.sv
calc_controller.sv
calculator_top.sv
calculator_properties.sv
calculator_tb.sv

//--- Makefile
SIM  ?= verilator
TOP  ?= calculator_tb
LOG  ?= sim.log
SEED ?= 4208283646
OBJ  ?= obj_dir

FAIL_MSG := Test failures found

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench, log in $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: SIM TOP LOG SEED OBJ"

test:
	$(SIM) --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ) \
		-Gseed=$(SEED) -f calculator.f
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; else echo "PASS"; fi

clean:
	rm -rf $(OBJ) $(LOG)

//--- calculator_tb.sv
// Calculator testbench: replays key sequences from the vector file and checks each result
`default_nettype none
`include "calc_defs.svh"

module calculator_tb #(
    parameter logic [31:0] seed = 32'hfad5_4ffe
);
    timeunit 1ns;
    timeprecision 100ps;

    import calc_pkg::*;

    logic       clk;
    logic       nRST;
    key_event_t key_in;
    logic       key_valid;
    logic       key_ready;
    result_t    result_out;
    logic       result_valid;
    logic       result_ready;

    key_event_t  keys[$];
    result_t     expects[$];
    logic [31:0] lfsr;
    logic        running;
    logic        b0;
    logic        b1;
    int          sent_count;
    int          checked_count;
    int          n_expect;
    int          n_records;
    int          error_count;
    int          cycles;
    int          cycle_limit;

    calculator_top i_calculator_top (
        .clk(clk), .nRST(nRST),
        .key_in(key_in), .key_valid(key_valid), .key_ready(key_ready),
        .result_out(result_out), .result_valid(result_valid),
        .result_ready(result_ready)
    );

    bind calc_controller calculator_properties i_props (.*);

    always #2 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bit(output logic bit_out);
        lfsr    = lfsr_next(lfsr);
        bit_out = lfsr[0];
    endtask

    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_result(input result_t got);
        result_t want;
        if (expects.size() == 0) begin
            $display("Extra result seen with no result expected (op %0d, sign %0d, mag %0d)",
                     got.op, got.value.sign, got.value.mag);
            error_count++;
            stop_on_failure();
        end else begin
            want = expects.pop_front();
            checked_count++;
            if (got !== want) begin
                $display("MISMATCH at %0t: result %0d got op %0d sign %0d mag %0d, %s %0d %0d %0d",
                         $time, checked_count, got.op, got.value.sign, got.value.mag,
                         "expected op sign mag", want.op, want.value.sign, want.value.mag);
                error_count++;
                stop_on_failure();
            end
        end
    endtask

    task automatic load_vectors();
        int         fd;
        int         got;
        int         a;
        int         b;
        int         c;
        byte        tag;
        string      line;
        key_event_t kev;
        result_t    res;
        fd = $fopen("calculator_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file calculator_vectors.txt");
            stop_on_failure();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                got  = $fgets(line, fd);
                if (got > 0 && line.getc(0) != "#") begin
                    got = $sscanf(line, "%c %d %d %d", tag, a, b, c);
                    if (got == 4 && tag == "k") begin
                        kev.kind  = key_kind_t'(a[1:0]);
                        kev.digit = b[3:0];
                        kev.op    = op_code_t'(c[1:0]);
                        keys.push_back(kev);
                        n_records++;
                    end else if (got == 4 && tag == "e") begin
                        res.op         = op_code_t'(a[1:0]);
                        res.value.sign = b[0];
                        res.value.mag  = c[`MAG_WIDTH-1:0];
                        expects.push_back(res);
                        n_records++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Key driver, result sink, timeout and assertion watch
    always @(posedge clk) begin
        if (running) begin
            cycles++;
            if (key_valid && key_ready) begin
                sent_count++;
            end
            if (!key_valid || key_ready) begin
                draw_bit(b0);
                draw_bit(b1);
                if (sent_count < keys.size() && !(b0 && b1)) begin
                    key_in    <= keys[sent_count];
                    key_valid <= 1'b1;
                end else begin
                    key_valid <= 1'b0;
                end
            end
            if (result_valid && result_ready) begin
                check_result(result_out);
            end
            draw_bit(b0);
            draw_bit(b1);
            result_ready <= !(b0 && b1);
            if (i_calculator_top.i_calc_controller.i_props.fail_count != 0) begin
                $display("A controller assertion failed at %0t", $time);
                error_count++;
                stop_on_failure();
            end else if (cycles >= cycle_limit) begin
                $display("Timed out after %0d cycles with %0d of %0d results checked",
                         cycles, checked_count, n_expect);
                stop_on_failure();
            end
        end
    end

    initial begin
        clk           = 1'b0;
        nRST          = 1'b0;
        key_in        = '0;
        key_valid     = 1'b0;
        result_ready  = 1'b0;
        lfsr          = seed;
        running       = 1'b0;
        sent_count    = 0;
        checked_count = 0;
        n_records     = 0;
        error_count   = 0;
        cycles        = 0;
        load_vectors();
        n_expect    = expects.size();
        cycle_limit = n_records * 40 + 200;
        if (n_expect == 0) begin
            $display("The vector file holds no expected results");
            stop_on_failure();
        end
        repeat (16) @(posedge clk);
        nRST    <= 1'b1;
        running <= 1'b1;
        wait (checked_count == n_expect);
        // Let any duplicate result show up
        repeat (50) @(posedge clk);
        if (error_count == 0 && expects.size() == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "errors were recorded");
        end
    end

endmodule

`default_nettype wire

//--- calculator_properties.sv
// Assertions on the calculator controller, bound into calc_controller by the testbench
`default_nettype none
`include "calc_defs.svh"

module calculator_properties (
    input wire logic                  clk,
    input wire logic                  nRST,
    input wire calc_pkg::calc_state_t state,
    input wire logic                  key_ready,
    input wire calc_pkg::result_t     result,
    input wire logic                  result_valid,
    input wire logic                  result_ready,
    input wire logic                  add_start,
    input wire logic                  mul_start,
    input wire logic                  add_finish,
    input wire logic                  mul_finish
);
    timeunit 1ns;
    timeprecision 100ps;

    import calc_pkg::*;

    int fail_count = 0;

    reset_outputs_low: assert property (@(posedge clk)
        !nRST |-> !result_valid && !key_ready)
        else begin
            fail_count++;
            $error("result_valid or key_ready high during reset");
        end

    result_held: assert property (@(posedge clk) disable iff (!nRST)
        result_valid && !result_ready |=> result_valid && $stable(result))
        else begin
            fail_count++;
            $error("result payload changed while stalled");
        end

    // Units are only started from the wait states
    no_start_in_entry: assert property (@(posedge clk) disable iff (!nRST)
        (add_start || mul_start) |-> !(state == ST_ENTER1 || state == ST_ENTER2))
        else begin
            fail_count++;
            $error("start pulse while in an entry state");
        end

    add_finishes: assert property (@(posedge clk) disable iff (!nRST)
        add_start |-> ##2 add_finish)
        else begin
            fail_count++;
            $error("adder finish missing two cycles after start");
        end

    mul_finishes: assert property (@(posedge clk) disable iff (!nRST)
        mul_start |-> ##(`MAG_WIDTH + 1) mul_finish)
        else begin
            fail_count++;
            $error("multiplier finish missing after start");
        end

endmodule

`default_nettype wire

//--- calculator_top.sv
// Calculator core top: key queue, entry controller, arithmetic units and result queue
`default_nettype none

module calculator_top (
    input  wire logic                 clk,
    input  wire logic                 nRST,
    input  wire calc_pkg::key_event_t key_in,
    input  wire logic                 key_valid,
    output logic                      key_ready,
    output calc_pkg::result_t         result_out,
    output logic                      result_valid,
    input  wire logic                 result_ready
);
    import calc_pkg::*;

    key_event_t ctl_key;
    logic       ctl_key_valid;
    logic       ctl_key_ready;
    result_t    ctl_result;
    logic       ctl_result_valid;
    logic       ctl_result_ready;
    sm_word_t   add_a;
    sm_word_t   add_b;
    sm_word_t   add_sum;
    sm_word_t   mul_a;
    sm_word_t   mul_b;
    sm_word_t   mul_product;
    logic       add_sub;
    logic       add_start;
    logic       add_finish;
    logic       mul_start;
    logic       mul_finish;

    event_fifo #(.payload_t(key_event_t)) i_key_fifo (
        .clk(clk), .nRST(nRST),
        .in_data(key_in), .in_valid(key_valid), .in_ready(key_ready),
        .out_data(ctl_key), .out_valid(ctl_key_valid), .out_ready(ctl_key_ready)
    );

    calc_controller i_calc_controller (
        .clk(clk), .nRST(nRST),
        .key(ctl_key), .key_valid(ctl_key_valid), .key_ready(ctl_key_ready),
        .result(ctl_result), .result_valid(ctl_result_valid),
        .result_ready(ctl_result_ready),
        .add_a(add_a), .add_b(add_b), .mul_a(mul_a), .mul_b(mul_b),
        .add_sub(add_sub), .add_start(add_start), .mul_start(mul_start),
        .add_sum(add_sum), .mul_product(mul_product),
        .add_finish(add_finish), .mul_finish(mul_finish)
    );

    sm_addsub i_sm_addsub (
        .clk(clk), .nRST(nRST),
        .a(add_a), .b(add_b), .sub(add_sub), .start(add_start),
        .sum(add_sum), .finish(add_finish)
    );

    // Also used for the times-ten step of digit entry
    sm_multiply i_sm_multiply (
        .clk(clk), .nRST(nRST),
        .a(mul_a), .b(mul_b), .start(mul_start),
        .product(mul_product), .finish(mul_finish)
    );

    event_fifo #(.payload_t(result_t)) i_result_fifo (
        .clk(clk), .nRST(nRST),
        .in_data(ctl_result), .in_valid(ctl_result_valid), .in_ready(ctl_result_ready),
        .out_data(result_out), .out_valid(result_valid), .out_ready(result_ready)
    );

endmodule

`default_nettype wire

//--- calc_controller.sv
// Keypad entry FSM: builds two operands from key events and sequences the arithmetic units
`default_nettype none
`include "calc_defs.svh"

module calc_controller (
    input  wire logic                 clk,
    input  wire logic                 nRST,
    input  wire calc_pkg::key_event_t key,
    input  wire logic                 key_valid,
    output logic                      key_ready,
    output calc_pkg::result_t         result,
    output logic                      result_valid,
    input  wire logic                 result_ready,
    output calc_pkg::sm_word_t        add_a,
    output calc_pkg::sm_word_t        add_b,
    output calc_pkg::sm_word_t        mul_a,
    output calc_pkg::sm_word_t        mul_b,
    output logic                      add_sub,
    output logic                      add_start,
    output logic                      mul_start,
    input  wire calc_pkg::sm_word_t   add_sum,
    input  wire calc_pkg::sm_word_t   mul_product,
    input  wire logic                 add_finish,
    input  wire logic                 mul_finish
);
    import calc_pkg::*;

    localparam sm_word_t base_word = '{sign: 1'b0, mag: `MAG_WIDTH'(`DIGIT_BASE)};

    calc_state_t            state;
    calc_state_t            state_next;
    sm_word_t               op_a;
    sm_word_t               op_b;
    sm_word_t               cur_op;
    op_code_t               op_q;
    logic [3:0]             digit_q;
    logic                   key_take;
    logic                   digit_take;
    logic                   unit_finish;
    sm_word_t               unit_result;
    logic [`CALC_WIDTH-1:0] digit_sum;

    assign key_take    = key_valid && key_ready;
    assign digit_take  = key_take && (key.kind == KEY_DIGIT);
    assign unit_finish = (op_q == OP_MUL) ? mul_finish : add_finish;
    assign unit_result = (op_q == OP_MUL) ? mul_product : add_sum;

    // Operand being entered
    assign cur_op    = (state == ST_ENTER2 || state == ST_ADD2) ? op_b : op_a;
    assign digit_sum = {1'b0, cur_op.mag} + `CALC_WIDTH'(digit_q);

    always_comb begin
        state_next = state;
        case (state)
            ST_ENTER1: begin
                if (key_take && key.kind == KEY_DIGIT) begin
                    state_next = ST_MUL1;
                end else if (key_take && key.kind == KEY_OP) begin
                    state_next = ST_ENTER2;
                end
            end
            ST_MUL1: begin
                if (mul_finish) begin
                    state_next = ST_ADD1;
                end
            end
            ST_ADD1:  state_next = ST_ENTER1;
            ST_ENTER2: begin
                if (key_take && key.kind == KEY_DIGIT) begin
                    state_next = ST_MUL2;
                end else if (key_take && key.kind == KEY_EQUAL) begin
                    state_next = ST_COMPUTE;
                end
            end
            ST_MUL2: begin
                if (mul_finish) begin
                    state_next = ST_ADD2;
                end
            end
            ST_ADD2:    state_next = ST_ENTER2;
            ST_COMPUTE: state_next = ST_WAIT;
            ST_WAIT: begin
                if (unit_finish) begin
                    state_next = ST_SHOW;
                end
            end
            ST_SHOW: begin
                if (result_valid && result_ready) begin
                    state_next = ST_ENTER1;
                end
            end
            default: state_next = ST_ENTER1;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state        <= ST_ENTER1;
            key_ready    <= 1'b0;
            add_start    <= 1'b0;
            mul_start    <= 1'b0;
            result_valid <= 1'b0;
            op_a         <= '0;
            op_b         <= '0;
            op_q         <= OP_ADD;
        end else begin
            state     <= state_next;
            key_ready <= (state_next == ST_ENTER1) || (state_next == ST_ENTER2);
            add_start <= (state == ST_COMPUTE) && (op_q != OP_MUL);
            mul_start <= digit_take || ((state == ST_COMPUTE) && (op_q == OP_MUL));

            // equal in ST_ENTER1 falls through untouched
            if (key_take && key.kind == KEY_SIGN && state == ST_ENTER1) begin
                op_a.sign <= 1'b1;
            end
            if (key_take && key.kind == KEY_SIGN && state == ST_ENTER2) begin
                op_b.sign <= 1'b1;
            end
            if (key_take && key.kind == KEY_OP) begin
                op_q <= key.op;
            end

            // Sign is kept across the times-ten step
            case (state)
                ST_MUL1: begin
                    if (mul_finish) begin
                        op_a.mag <= mul_product.mag;
                    end
                end
                ST_ADD1: op_a.mag <= digit_sum[`MAG_WIDTH-1:0];
                ST_MUL2: begin
                    if (mul_finish) begin
                        op_b.mag <= mul_product.mag;
                    end
                end
                ST_ADD2: op_b.mag <= digit_sum[`MAG_WIDTH-1:0];
                ST_WAIT: begin
                    if (unit_finish) begin
                        result_valid <= 1'b1;
                    end
                end
                ST_SHOW: begin
                    if (result_ready) begin
                        result_valid <= 1'b0;
                        op_a         <= '0;
                        op_b         <= '0;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (digit_take) begin
            digit_q <= key.digit;
            mul_a   <= cur_op;
            mul_b   <= base_word;
        end else if (state == ST_COMPUTE) begin
            mul_a   <= op_a;
            mul_b   <= op_b;
            add_a   <= op_a;
            add_b   <= op_b;
            add_sub <= (op_q == OP_SUB);
        end
        if (state == ST_WAIT && unit_finish) begin
            result.op    <= op_q;
            result.value <= unit_result;
        end
    end

endmodule

`default_nettype wire

//--- sm_multiply.sv
// Shift-and-add sign-magnitude multiplier, shared by digit entry and the multiply op
`default_nettype none
`include "calc_defs.svh"

module sm_multiply (
    input  wire logic               clk,
    input  wire logic               nRST,
    input  wire calc_pkg::sm_word_t a,
    input  wire calc_pkg::sm_word_t b,
    input  wire logic               start,
    output calc_pkg::sm_word_t      product,
    output logic                    finish
);
    import calc_pkg::*;

    localparam int step_w = $clog2(`MAG_WIDTH);

    logic [`MAG_WIDTH-1:0] mcand;
    logic [`MAG_WIDTH-1:0] mplier;
    logic [`MAG_WIDTH-1:0] acc;
    logic [`MAG_WIDTH-1:0] acc_next;
    logic                  sign_q;
    logic [step_w-1:0]     step;
    logic                  busy;
    logic                  last_step;

    // Partial product only kept modulo the magnitude range
    assign acc_next  = acc + (mplier[0] ? mcand : '0);
    assign last_step = busy && (step == step_w'(`MAG_WIDTH - 1));

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            step   <= '0;
            finish <= 1'b0;
        end else begin
            finish <= last_step;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (last_step) begin
                busy <= 1'b0;
            end else if (busy) begin
                step <= step + 1'b1;
            end
        end
    end

    // One multiplier bit per cycle
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= a.mag;
            mplier <= b.mag;
            acc    <= '0;
            sign_q <= a.sign ^ b.sign;
        end else if (busy) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            acc    <= acc_next;
        end
        if (last_step) begin
            product <= sm_pack(sign_q, {1'b0, acc_next});
        end
    end

endmodule

`default_nettype wire

//--- sm_addsub.sv
// Two-cycle sign-magnitude adder/subtractor, started and finished by one-cycle pulses
`default_nettype none
`include "calc_defs.svh"

module sm_addsub (
    input  wire logic               clk,
    input  wire logic               nRST,
    input  wire calc_pkg::sm_word_t a,
    input  wire calc_pkg::sm_word_t b,
    input  wire logic               sub,
    input  wire logic               start,
    output calc_pkg::sm_word_t      sum,
    output logic                    finish
);
    import calc_pkg::*;

    sm_word_t               a_q;
    sm_word_t               b_q;
    logic                   a_ge_b;
    logic                   busy;
    logic [`CALC_WIDTH-1:0] raw;
    logic                   raw_sign;

    // Larger magnitude sets the sign when signs differ
    always_comb begin
        if (a_q.sign == b_q.sign) begin
            raw      = {1'b0, a_q.mag} + {1'b0, b_q.mag};
            raw_sign = a_q.sign;
        end else if (a_ge_b) begin
            raw      = {1'b0, a_q.mag - b_q.mag};
            raw_sign = a_q.sign;
        end else begin
            raw      = {1'b0, b_q.mag - a_q.mag};
            raw_sign = b_q.sign;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            finish <= 1'b0;
        end else begin
            busy   <= start;
            finish <= busy;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            a_q      <= a;
            b_q.sign <= b.sign ^ sub;
            b_q.mag  <= b.mag;
            a_ge_b   <= (a.mag >= b.mag);
        end
        if (busy) begin
            sum <= sm_pack(raw_sign, raw);
        end
    end

endmodule

`default_nettype wire

//--- event_fifo.sv
// Small valid/ready circular queue; payload type is set per instance (key events, results)
`default_nettype none
`include "calc_defs.svh"

module event_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = `FIFO_DEPTH
) (
    input  wire logic     clk,
    input  wire logic     nRST,
    input  wire payload_t in_data,
    input  wire logic     in_valid,
    output logic          in_ready,
    output payload_t      out_data,
    output logic          out_valid,
    input  wire logic     out_ready
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] count_next;
    logic             push;
    logic             pop;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push     = in_valid && in_ready;
    assign pop      = out_valid && out_ready;
    assign out_data = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    // Flags registered from the next occupancy
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_ready  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count     <= count_next;
            in_ready  <= (count_next != cnt_w'(depth));
            out_valid <= (count_next != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- calc_pkg.sv
// Shared number, key, result and FSM state types; imported by the calculator modules
`default_nettype none
`include "calc_defs.svh"

package calc_pkg;

    typedef struct packed {
        logic                  sign;
        logic [`MAG_WIDTH-1:0] mag;
    } sm_word_t;

    typedef enum logic [1:0] {
        KEY_DIGIT,
        KEY_SIGN,
        KEY_OP,
        KEY_EQUAL
    } key_kind_t;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL
    } op_code_t;

    typedef struct packed {
        key_kind_t  kind;
        logic [3:0] digit;
        op_code_t   op;
    } key_event_t;

    typedef struct packed {
        op_code_t op;
        sm_word_t value;
    } result_t;

    typedef enum logic [3:0] {
        ST_ENTER1,
        ST_MUL1,
        ST_ADD1,
        ST_ENTER2,
        ST_MUL2,
        ST_ADD2,
        ST_COMPUTE,
        ST_WAIT,
        ST_SHOW
    } calc_state_t;

    // Magnitude wraps, and a zero value is always positive
    function automatic sm_word_t sm_pack(input logic sign, input logic [`CALC_WIDTH-1:0] raw);
        sm_word_t word;
        word.mag  = raw[`MAG_WIDTH-1:0];
        word.sign = sign && (word.mag != '0);
        return word;
    endfunction

endpackage

`default_nettype wire

//--- calc_defs.svh
// Width, base and depth macros, included by the calculator RTL and testbench files
`ifndef CALC_DEFS_SVH
`define CALC_DEFS_SVH

// Sign bit plus magnitude
`define CALC_WIDTH 16
`define MAG_WIDTH 15

// Running operand is scaled by this before each digit is added
`define DIGIT_BASE 10

`define FIFO_DEPTH 4

`endif
